/* design/bcd_pkg.sv */
`default_nettype none

package bcd_pkg;

  // ############################
  // digit format
  // ############################

  localparam int DIGIT_W = 4;  // one decimal digit.

  typedef logic [DIGIT_W-1:0] bcd_digit_t;  // holds 0 to 9 between steps.

  // ############################
  // sequencer states
  // ############################

  typedef enum logic [3:0] {
    IDLE       = 4'd0,  // waiting for start with digits held clear.
    SHIFT      = 4'd1,
    CHECK      = 4'd2,  // look for digits of 5 or more.
    LOAD       = 4'd3,  // add 3 where flagged.
    ITERATE    = 4'd4,
    LAST_SHIFT = 4'd5,  // final bit with no correction after it.
    DONE       = 4'd6
  } ctrl_state_t;

endpackage : bcd_pkg

`default_nettype wire

/* design/bcd_digit_cell.sv */
`default_nettype none

module bcd_digit_cell
  import bcd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       clear,
  input  logic       shift,
  input  logic       load,
  input  logic       serial_in,
  output bcd_digit_t digit,
  output logic       ge5
);

  // ############################
  // digit register
  // ############################

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      digit <= '0;
    end else if (shift) begin
      digit <= {digit[DIGIT_W-2:0], serial_in};  // MSB leaves to the next cell.
    end else if (load) begin
      digit <= digit + bcd_digit_t'(3);
    end
  end

  // 5 or more would double past 9 on the next shift.
  assign ge5 = (digit >= bcd_digit_t'(5));

endmodule : bcd_digit_cell

`default_nettype wire

/* design/bin_shift_reg.sv */
`default_nettype none

module bin_shift_reg #(
  parameter int BIN_WIDTH = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 capture,
  input  logic [BIN_WIDTH-1:0] bin_in,
  input  logic                 shift,
  input  logic                 count,
  output logic                 shift_out,
  output logic                 last
);

  localparam int CNT_W = $clog2(BIN_WIDTH + 1);

  logic [BIN_WIDTH-1:0] operand;
  logic [CNT_W-1:0]     bit_cnt;  // bits not yet counted off.

  always_ff @(posedge clk) begin
    if (capture) begin
      operand <= bin_in;
    end else if (shift) begin
      operand <= operand << 1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (capture) begin
      bit_cnt <= CNT_W'(BIN_WIDTH);
    end else if (count && (bit_cnt != '0)) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  assign shift_out = operand[BIN_WIDTH-1];  // MSB goes into the units cell.

  // in ITERATE the current bit is still uncounted, so 2 here means
  // only one bit is left to shift afterwards.
  assign last = (bit_cnt == CNT_W'(2));

endmodule : bin_shift_reg

`default_nettype wire

/* design/bcd_result_reg.sv */
`default_nettype none

module bcd_result_reg
  import bcd_pkg::*;
#(
  parameter int NUM_DIGITS = 3
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          done,
  input  logic [NUM_DIGITS*DIGIT_W-1:0] digits,
  output logic [NUM_DIGITS*DIGIT_W-1:0] bcd_out,
  output logic                          valid
);

  always_ff @(posedge clk) begin
    if (rst) begin
      bcd_out <= '0;
      valid   <= 1'b0;
    end else begin
      valid <= done;  // single cycle as DONE lasts one cycle.
      if (done) begin
        bcd_out <= digits;  // held until the next result.
      end
    end
  end

endmodule : bcd_result_reg

`default_nettype wire

/* design/bcd_control.sv */
`default_nettype none

module bcd_control
  import bcd_pkg::*;
#(
  parameter int NUM_DIGITS = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  last,
  input  logic [NUM_DIGITS-1:0] ge5,
  output logic                  clear,
  output logic                  capture,
  output logic                  shift,
  output logic [NUM_DIGITS-1:0] digit_load,
  output logic                  count,
  output logic                  done,
  output logic                  busy
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic [NUM_DIGITS-1:0] load_flags;  // ge5 snapshot taken in CHECK.

  // ############################
  // state register
  // ############################

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (state == CHECK) begin
      load_flags <= ge5;
    end
  end

  // ############################
  // next state
  // ############################

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_nxt = SHIFT;
        end
      end
      SHIFT: begin
        state_nxt = CHECK;
      end
      CHECK: begin
        state_nxt = (|ge5) ? LOAD : ITERATE;  // skip LOAD when nothing to fix.
      end
      LOAD: begin
        state_nxt = ITERATE;
      end
      ITERATE: begin
        state_nxt = last ? LAST_SHIFT : SHIFT;
      end
      LAST_SHIFT: begin
        state_nxt = DONE;
      end
      DONE: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // ############################
  // control strobes
  // ############################

  always_comb begin
    clear      = 1'b0;
    capture    = 1'b0;
    shift      = 1'b0;
    digit_load = '0;
    count      = 1'b0;
    done       = 1'b0;
    case (state)
      IDLE: begin
        clear   = 1'b1;
        capture = start;  // operand taken on the start edge.
      end
      SHIFT, LAST_SHIFT: begin
        shift = 1'b1;
      end
      LOAD: begin
        digit_load = load_flags;
      end
      ITERATE: begin
        count = 1'b1;
      end
      DONE: begin
        done = 1'b1;
      end
      default: begin
        clear = 1'b0;
      end
    endcase
  end

  assign busy = (state != IDLE);

endmodule : bcd_control

`default_nettype wire

/* design/bin2bcd.sv */
`default_nettype none

module bin2bcd
  import bcd_pkg::*;
#(
  parameter int BIN_WIDTH  = 8,
  parameter int NUM_DIGITS = 3
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic [BIN_WIDTH-1:0]          bin_in,
  output logic                          busy,
  output logic [NUM_DIGITS*DIGIT_W-1:0] bcd_out,
  output logic                          valid
);

  logic                          clear;
  logic                          capture;
  logic                          shift;
  logic                          count;
  logic                          done;
  logic                          last;
  logic                          shift_out;
  logic [NUM_DIGITS-1:0]         ge5;
  logic [NUM_DIGITS-1:0]         digit_load;
  logic [NUM_DIGITS*DIGIT_W-1:0] digits;  // units digit at the bottom.

  // ############################
  // operand feeder
  // ############################

  bin_shift_reg #(
    .BIN_WIDTH(BIN_WIDTH)
  ) feeder_i (
    .clk      (clk),
    .rst      (rst),
    .capture  (capture),
    .bin_in   (bin_in),
    .shift    (shift),
    .count    (count),
    .shift_out(shift_out),
    .last     (last)
  );

  // ############################
  // digit chain
  // ############################

  for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
    logic serial_in;

    if (i == 0) begin : g_first
      assign serial_in = shift_out;
    end else begin : g_next
      assign serial_in = digits[i*DIGIT_W-1];  // MSB of the lower digit.
    end

    bcd_digit_cell cell_i (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .shift    (shift),
      .load     (digit_load[i]),
      .serial_in(serial_in),
      .digit    (digits[i*DIGIT_W +: DIGIT_W]),
      .ge5      (ge5[i])
    );
  end

  bcd_result_reg #(
    .NUM_DIGITS(NUM_DIGITS)
  ) drain_i (
    .clk    (clk),
    .rst    (rst),
    .done   (done),
    .digits (digits),
    .bcd_out(bcd_out),
    .valid  (valid)
  );

  // ############################
  // sequencer
  // ############################

  bcd_control #(
    .NUM_DIGITS(NUM_DIGITS)
  ) control_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .last      (last),
    .ge5       (ge5),
    .clear     (clear),
    .capture   (capture),
    .shift     (shift),
    .digit_load(digit_load),
    .count     (count),
    .done      (done),
    .busy      (busy)
  );

endmodule : bin2bcd

`default_nettype wire

/* sim/tb_bin2bcd.sv */
`default_nettype none

module tb_bin2bcd
  import bcd_pkg::*;
();

  localparam int BIN_WIDTH  = 8;
  localparam int NUM_DIGITS = 3;
  localparam int BCD_W      = NUM_DIGITS * DIGIT_W;
  localparam int NUM_VECS   = 12;
  localparam int NUM_RANDOM = 40;
  localparam int MIN_LAT    = 3 * (BIN_WIDTH - 1) + 3;  // no LOAD state on any bit.
  localparam int MAX_LAT    = 4 * (BIN_WIDTH - 1) + 3;  // cycles from the start edge.
  localparam int WATCHDOG_CYCLES = (NUM_VECS + NUM_RANDOM + 4) * (4 * BIN_WIDTH + 8);

  // ############################
  // stimulus table
  // ############################

  localparam logic [BIN_WIDTH-1:0] TABLE_BIN [NUM_VECS] = '{
    8'd0, 8'd1, 8'd4, 8'd5, 8'd9, 8'd10, 8'd49, 8'd99, 8'd100, 8'd128, 8'd199, 8'd255
  };
  localparam logic [BCD_W-1:0] TABLE_BCD [NUM_VECS] = '{
    12'h000, 12'h001, 12'h004, 12'h005, 12'h009, 12'h010,
    12'h049, 12'h099, 12'h100, 12'h128, 12'h199, 12'h255
  };

  logic                 clk;
  logic                 rst;
  logic                 start;
  logic [BIN_WIDTH-1:0] bin_in;
  logic                 busy;
  logic [BCD_W-1:0]     bcd_out;
  logic                 valid;
  int                   seed;

  bin2bcd #(
    .BIN_WIDTH (BIN_WIDTH),
    .NUM_DIGITS(NUM_DIGITS)
  ) dut_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .bin_in (bin_in),
    .busy   (busy),
    .bcd_out(bcd_out),
    .valid  (valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ############################
  // helpers
  // ############################

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bcd(input logic [BCD_W-1:0] got, input logic [BCD_W-1:0] exp,
                           input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %0t: %s is %b, expected %b",
                                  $time, what, got, exp));
    end
  endtask

  // each digit is the value divided by a power of ten, modulo 10.
  function automatic logic [BCD_W-1:0] decimal_bcd(input logic [BIN_WIDTH-1:0] v);
    logic [BCD_W-1:0] r;
    int unsigned      rest;
    rest = 32'(v);
    for (int d = 0; d < NUM_DIGITS; d++) begin
      r[d*DIGIT_W +: DIGIT_W] = bcd_digit_t'(rest % 10);
      rest = rest / 10;
    end
    return r;
  endfunction

  task automatic wait_cycle();
    @(posedge clk);
    #1;  // outputs settled and inputs change here.
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      wait_cycle();
      check_bit(valid, 1'b0, "valid with no conversion running");
      check_bit(busy, 1'b0, "busy while idle");
    end
  endtask

  // one conversion; optionally a second start while busy, which must be ignored.
  task automatic run_conversion(input logic [BIN_WIDTH-1:0] value,
                                input logic [BCD_W-1:0] expected,
                                input logic restart,
                                input logic [BIN_WIDTH-1:0] other);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    start  = 1'b1;
    bin_in = value;
    while (!seen) begin
      wait_cycle();
      cycles++;
      start  = restart && (cycles == 4);
      bin_in = start ? other : ~value;  // operand is already captured.
      if (valid) begin
        seen = 1'b1;
        if (cycles < MIN_LAT) begin
          stop_with_failure("valid arrived earlier than the shortest possible latency");
        end
      end else begin
        check_bit(busy, 1'b1, "busy during conversion");
        if (cycles >= MAX_LAT) begin
          stop_with_failure("no valid pulse arrived within the latency bound");
        end
      end
    end
    check_bit(busy, 1'b0, "busy at valid");
    check_bcd(bcd_out, expected, $sformatf("bcd_out for %0d", value));
    wait_cycle();
    check_bit(valid, 1'b0, "valid one cycle after the pulse");
    check_bcd(bcd_out, expected, "bcd_out held after valid");
  endtask

  // ############################
  // test sequence
  // ############################

  initial begin
    int                   rnd;
    logic [BIN_WIDTH-1:0] value;
    seed   = 52920;
    rst    = 1'b1;
    start  = 1'b0;
    bin_in = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(valid, 1'b0, "valid after reset");
    check_bcd(bcd_out, '0, "bcd_out after reset");

    for (int i = 0; i < NUM_VECS; i++) begin
      run_conversion(TABLE_BIN[i], TABLE_BCD[i], 1'b0, '0);
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd   = $random(seed);
      value = rnd[BIN_WIDTH-1:0];
      run_conversion(value, decimal_bcd(value), 1'b0, '0);
    end

    run_conversion(8'd37, 12'h037, 1'b1, 8'd250);  // start while busy.
    expect_quiet(MAX_LAT);

    start  = 1'b1;  // reset in the middle of a conversion.
    bin_in = 8'd231;
    wait_cycle();
    start = 1'b0;
    repeat (8) wait_cycle();
    check_bit(busy, 1'b1, "busy before mid-conversion reset");
    rst = 1'b1;
    repeat (2) begin
      wait_cycle();
      check_bit(busy, 1'b0, "busy in reset");
      check_bit(valid, 1'b0, "valid in reset");
    end
    rst = 1'b0;
    expect_quiet(MAX_LAT);
    run_conversion(8'd173, 12'h173, 1'b0, '0);

    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    stop_with_failure("the run timed out before all tests finished");
  end

endmodule : tb_bin2bcd

`default_nettype wire

/* filelist.f */
design/bcd_pkg.sv
design/bcd_digit_cell.sv
design/bin_shift_reg.sv
design/bcd_result_reg.sv
design/bcd_control.sv
design/bin2bcd.sv
sim/tb_bin2bcd.sv

/* run.sh */
#!/bin/sh
# build and run the bin2bcd testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_bin2bcd -f filelist.f -o sim_bin2bcd \
  && ./obj_dir/sim_bin2bcd \
  || exit 1
